/* bench/adc_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_defs.svh"

module adc_tb;
    import adc_pkg::*;

    localparam int LIMIT = 200000; // Cycles before the run counts as hung.
    localparam int KW    = 2 * `N_SLOT;
    localparam int CW    = 8 * `N_SLOT;

    logic               sys_clk;
    logic               rst_n;
    logic               fs_conf;
    logic               fs_read;
    logic               fd_conf;
    logic               fd_read;
    logic [KW-1:0]      dev_kind;
    logic [CW-1:0]      adc_cmd;
    logic               adc_rxen;
    logic [7:0]         adc_rxd;
    logic               adc_ready;
    logic               fifoa_full;
    logic               fifoa_empty;
    wire  [`N_SLOT-1:0] spi_sclk;
    wire  [`N_SLOT-1:0] spi_cs_n;
    wire  [`N_SLOT-1:0] spi_mosi;
    wire  [`N_SLOT-1:0] spi_miso;
    sample_t            next_smp [`N_SLOT];
    sample_t            rx_word [`N_SLOT];
    sample_t            tx_word [`N_SLOT];
    int                 xfer_bits [`N_SLOT];
    int                 xfer_cnt [`N_SLOT];
    int                 cnt_seen [`N_SLOT];
    byte_t              exp_q [$];     // Bytes the stream still owes.
    int                 cycles = 0;
    int                 n_fd_conf = 0;
    int                 n_fd_read = 0;

    clk_gen clk_i (.clk(sys_clk), .rst_n(rst_n));

    for (genvar i = 0; i < `N_SLOT; i++) begin : g_conv
        conv_model conv_i (
            .sclk      (spi_sclk[i]),
            .cs_n      (spi_cs_n[i]),
            .mosi      (spi_mosi[i]),
            .miso      (spi_miso[i]),
            .next_smp  (next_smp[i]),
            .rx_word   (rx_word[i]),
            .tx_word   (tx_word[i]),
            .xfer_bits (xfer_bits[i]),
            .xfer_cnt  (xfer_cnt[i])
        );
    end

    adc dut_i (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s is %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    task automatic step();
        @(posedge sys_clk);
        #2;
    endtask

    // Outputs are sampled on the falling edge, halfway between drives.
    always @(negedge sys_clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            abort_run($sformatf("Timeout, run still busy after %0d cycles.", LIMIT));
        end
        if (rst_n) begin
            if (fd_conf) n_fd_conf = n_fd_conf + 1;
            if (fd_read) n_fd_read = n_fd_read + 1;
            if (adc_rxen && adc_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("Stream delivered a byte that no read produced.");
                end
                check(32'(adc_rxd), 32'(exp_q.pop_front()), "stream byte");
            end
            for (int i = 0; i < `N_SLOT; i++) begin
                if (dev_kind[2*i +: 2] == 2'b00 && !spi_cs_n[i]) begin
                    abort_run($sformatf("Absent slot %0d has its chip select low.", i));
                end
            end
        end
    end

    function automatic logic [KW-1:0] full_kinds();
        logic [KW-1:0] k;
        for (int i = 0; i < `N_SLOT; i++) begin
            k[2*i +: 2] = 2'(1 + $urandom_range(2)); // Never 00.
        end
        return k;
    endfunction

    task automatic snap_counts();
        for (int i = 0; i < `N_SLOT; i++) begin
            cnt_seen[i] = xfer_cnt[i];
        end
    endtask

    // Slot 0 upward, high byte first.
    task automatic expect_samples();
        for (int i = 0; i < `N_SLOT; i++) begin
            if (dev_kind[2*i +: 2] != 2'b00) begin
                exp_q.push_back(next_smp[i][15:8]);
                exp_q.push_back(next_smp[i][7:0]);
            end
        end
    endtask

    task automatic check_xfers(input logic conf);
        for (int i = 0; i < `N_SLOT; i++) begin
            if (dev_kind[2*i +: 2] == 2'b00) begin
                check(xfer_cnt[i], cnt_seen[i], $sformatf("slot %0d transfers", i));
            end else begin
                check(xfer_cnt[i], cnt_seen[i] + 1, $sformatf("slot %0d transfers", i));
                check(xfer_bits[i], 16, $sformatf("slot %0d SCLK count", i));
                if (conf) begin
                    check(32'(rx_word[i]), 32'({adc_cmd[8*i +: 8], 8'h00}),
                          $sformatf("slot %0d command word", i));
                end else begin
                    check(32'(rx_word[i]), 32'd0, $sformatf("slot %0d read MOSI", i));
                    check(32'(tx_word[i]), 32'(next_smp[i]), $sformatf("slot %0d sample", i));
                    next_smp[i] = sample_t'($urandom);
                end
            end
        end
    endtask

    task automatic pulse_start(input logic conf);
        fs_conf = conf;
        fs_read = !conf;
        step();
        fs_conf = 1'b0;
        fs_read = 1'b0;
    endtask

    task automatic wait_done(input logic conf, input int base);
        while ((conf ? n_fd_conf : n_fd_read) == base) begin
            step();
        end
        repeat (2) step();
        check(conf ? n_fd_conf : n_fd_read, base + 1, "done pulses");
    endtask

    task automatic run_op(input logic conf);
        int base;
        base = conf ? n_fd_conf : n_fd_read;
        snap_counts();
        if (!conf) expect_samples();
        pulse_start(conf);
        if (dev_kind == '0) begin
            check(conf ? n_fd_conf : n_fd_read, base, "done during start cycle");
            @(negedge sys_clk);
            check(32'(conf ? fd_conf : fd_read), 32'd1, "done one cycle after start");
        end
        wait_done(conf, base);
        check_xfers(conf);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || adc_rxen || !fifoa_empty) begin
            step();
        end
    endtask

    initial begin
        int n;
        int base;
        void'($urandom(32'haeb9));
        fs_conf   = 1'b0;
        fs_read   = 1'b0;
        dev_kind  = '0;
        adc_cmd   = '0;
        adc_ready = 1'b0;
        for (int i = 0; i < `N_SLOT; i++) begin
            next_smp[i] = sample_t'($urandom);
        end

        wait (rst_n === 1'b1);
        @(negedge sys_clk);
        check(32'(adc_rxen), 32'd0, "adc_rxen after reset");
        check(32'(fd_conf), 32'd0, "fd_conf after reset");
        check(32'(fd_read), 32'd0, "fd_read after reset");
        check(32'(fifoa_full), 32'd0, "fifoa_full after reset");
        check(32'(fifoa_empty), 32'd1, "fifoa_empty after reset");
        check(32'(spi_cs_n), 32'({`N_SLOT{1'b1}}), "spi_cs_n after reset");
        check(32'(spi_sclk), 32'd0, "spi_sclk after reset");
        step();

        dev_kind = full_kinds();
        adc_cmd  = CW'($urandom);
        run_op(1'b1);

        adc_ready = 1'b1;
        repeat (4) begin
            run_op(1'b0);
            wait_drained();
        end

        // Random population, round 3 has no device at all.
        for (int k = 0; k < 8; k++) begin
            dev_kind = (k == 3) ? '0 : KW'($urandom);
            run_op(1'b0);
            wait_drained();
        end

        // Fill every FIFO behind a stalled stream.
        dev_kind  = full_kinds();
        adc_ready = 1'b0;
        n = 0;
        while (!fifoa_full) begin
            if (n == 2 * `FIFO_DEPTH) begin
                abort_run("fifoa_full did not rise with adc_ready held low.");
            end
            run_op(1'b0);
            n++;
        end
        // Slot 0 hands its first sample to the output register.
        check(n, `FIFO_DEPTH, "reads until fifoa_full");
        base = n_fd_read;
        snap_counts();
        expect_samples();
        pulse_start(1'b0);
        while (n_fd_read == base || exp_q.size() != 0 || !fifoa_empty) begin
            adc_ready = 1'($urandom);
            step();
        end
        check(n_fd_read, base + 1, "fd_read pulses under back-pressure");
        check_xfers(1'b0);
        adc_ready = 1'b1;
        repeat (4) step();

        if (exp_q.size() == 0 && fifoa_empty && !adc_rxen) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Stream still holds data at the end of the run.");
        end
    end

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
    parameter int HALF_NS    = 10,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // Released just after an edge, like every other input.
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/conv_model.sv */
`timescale 1ns/1ns
`default_nettype none

// One SPI converter. Takes a 16-bit word in, sends next_smp back.
module conv_model (
    input  logic        sclk,
    input  logic        cs_n,
    input  logic        mosi,
    output logic        miso,
    input  logic [15:0] next_smp,  // Answer for the next transfer.
    output logic [15:0] rx_word,   // Last word in, command byte on top.
    output logic [15:0] tx_word,   // Last word out.
    output int          xfer_bits,
    output int          xfer_cnt
);
    logic [15:0] rx_sr;
    logic [15:0] tx_sr;
    logic [15:0] sent;
    int          nbit;
    logic        active;

    initial begin
        miso      = 1'b0;
        rx_word   = '0;
        tx_word   = '0;
        xfer_bits = 0;
        xfer_cnt  = 0;
        nbit      = 0;
        active    = 1'b0;
    end

    always @(negedge cs_n) begin
        sent   = next_smp;
        tx_sr  = next_smp;
        rx_sr  = '0;
        nbit   = 0;
        active = 1'b1;
        miso   = next_smp[15]; // First bit ready before the first rise.
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_sr = {rx_sr[14:0], mosi};
            nbit  = nbit + 1;
        end
    end

    always @(negedge sclk) begin
        if (!cs_n && nbit < 16) begin
            tx_sr = {tx_sr[14:0], 1'b0};
            miso  = tx_sr[15];
        end
    end

    always @(posedge cs_n) begin
        if (active) begin
            rx_word   = rx_sr;
            tx_word   = sent;
            xfer_bits = nbit;
            xfer_cnt  = xfer_cnt + 1;
            active    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/adc.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_defs.svh"

module adc (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 fs_conf,
    input  logic                 fs_read,
    output logic                 fd_conf,
    output logic                 fd_read,
    input  logic [2*`N_SLOT-1:0] dev_kind,
    input  logic [8*`N_SLOT-1:0] adc_cmd,   // Slot 0 in the low byte.
    output logic                 adc_rxen,
    output logic [7:0]           adc_rxd,
    input  logic                 adc_ready,
    output logic                 fifoa_full,
    output logic                 fifoa_empty,
    output logic [`N_SLOT-1:0]   spi_sclk,
    output logic [`N_SLOT-1:0]   spi_cs_n,
    output logic [`N_SLOT-1:0]   spi_mosi,
    input  logic [`N_SLOT-1:0]   spi_miso
);

    intan_if slot_bus [`N_SLOT] ();

    logic [`N_SLOT-1:0] full_v;
    logic [`N_SLOT-1:0] valid_v;

    slot_ctrl ctrl_i (
        .clk      (sys_clk),
        .rst_n    (rst_n),
        .fs_conf  (fs_conf),
        .fs_read  (fs_read),
        .dev_kind (dev_kind),
        .fd_conf  (fd_conf),
        .fd_read  (fd_read),
        .slots    (slot_bus)
    );

    for (genvar i = 0; i < `N_SLOT; i++) begin : g_fe
        intan fe_i (
            .clk   (sys_clk),
            .rst_n (rst_n),
            .cmd   (adc_cmd[8*i +: 8]),
            .bus   (slot_bus[i]),
            .sclk  (spi_sclk[i]),
            .cs_n  (spi_cs_n[i]),
            .mosi  (spi_mosi[i]),
            .miso  (spi_miso[i])
        );

        assign full_v[i]  = slot_bus[i].fifo_full;
        assign valid_v[i] = slot_bus[i].smp_valid;
    end

    fifo2adc drain_i (
        .clk       (sys_clk),
        .rst_n     (rst_n),
        .slots     (slot_bus),
        .adc_rxen  (adc_rxen),
        .adc_rxd   (adc_rxd),
        .adc_ready (adc_ready)
    );

    // Any slot full, or every slot empty.
    assign fifoa_full  = |full_v;
    assign fifoa_empty = ~|valid_v;

endmodule

`default_nettype wire

/* design/adc_defs.svh */
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// Number of converter slots behind the stream.
`define N_SLOT 4

`define SPI_DIV 4 // System clocks per SCLK half period.

// Samples held per slot FIFO.
`define FIFO_DEPTH 4

`define SMP_W 16 // One converter word.

`endif

/* design/adc_pkg.sv */
`default_nettype none
`include "adc_defs.svh"

package adc_pkg;

    // One converter sample.
    typedef logic [`SMP_W-1:0] sample_t;

    typedef logic [7:0] byte_t; // Stream byte or command byte.

    // Device kind per slot, zero means no device.
    typedef logic [1:0] kind_t;

    // Front-end sequencer.
    typedef enum logic [2:0] {
        IDLE,
        CONF_XFER,
        READ_WAIT,
        READ_XFER,
        DONE
    } fe_state_t;

endpackage

`default_nettype wire

/* design/fifo2adc.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_defs.svh"

module fifo2adc (
    input  logic           clk,
    input  logic           rst_n,
    intan_if.drain         slots [`N_SLOT],
    output logic           adc_rxen,
    output adc_pkg::byte_t adc_rxd,
    input  logic           adc_ready
);
    import adc_pkg::*;

    localparam int SW = $clog2(`N_SLOT);
    localparam logic [SW-1:0] SLOT_LAST = SW'(`N_SLOT - 1);

    sample_t            smp_a [`N_SLOT];
    logic [`N_SLOT-1:0] valid_v;
    logic [SW-1:0]      last;     // Slot served most recently.
    logic [SW-1:0]      sel;
    logic               found;
    logic               phase;    // Low byte on the output when set.
    sample_t            obuf;
    logic               hs;
    logic               load_ok;
    logic               pop;

    for (genvar i = 0; i < `N_SLOT; i++) begin : g_slot
        assign smp_a[i]           = slots[i].smp;
        assign valid_v[i]         = slots[i].smp_valid;
        assign slots[i].smp_ready = pop && (sel == SW'(i));
    end

    // Next slot with data, looking upward from the one after last.
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = last;
        for (int k = 1; k <= `N_SLOT; k++) begin
            idx = (int'(last) + k) % `N_SLOT;
            if (!found && valid_v[idx]) begin
                found = 1'b1;
                sel   = SW'(idx);
            end
        end
    end

    assign hs      = adc_rxen && adc_ready;
    assign load_ok = !adc_rxen || (hs && phase);
    assign pop     = load_ok && found;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adc_rxen <= 1'b0;
            phase    <= 1'b0;
            last     <= SLOT_LAST;
        end else begin
            if (pop) begin
                adc_rxen <= 1'b1;
                phase    <= 1'b0;
            end else if (hs) begin
                adc_rxen <= !phase;
                phase    <= !phase;
            end
            if (pop) begin
                last <= sel;
            end else if (!found) begin
                last <= SLOT_LAST; // All drained, next round starts at slot 0.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            obuf <= smp_a[sel];
        end
    end

    assign adc_rxd = phase ? obuf[7:0] : obuf[`SMP_W-1:8]; // High byte first.

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (adc_rxen && !adc_ready) |=> (adc_rxen && $stable(adc_rxd)));

endmodule

`default_nettype wire

/* design/intan.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_defs.svh"

module intan (
    input  logic           clk,
    input  logic           rst_n,
    input  adc_pkg::byte_t cmd,
    intan_if.fe            bus,
    output logic           sclk,
    output logic           cs_n,
    output logic           mosi,
    input  logic           miso
);
    import adc_pkg::*;

    localparam int DW = $clog2(`SPI_DIV);
    localparam int BW = $clog2(`SMP_W);
    localparam int PW = $clog2(`FIFO_DEPTH);
    localparam int CW = $clog2(`FIFO_DEPTH + 1);
    localparam logic [DW-1:0] DIV_LAST = DW'(`SPI_DIV - 1);
    localparam logic [BW-1:0] BIT_LAST = BW'(`SMP_W - 1);
    localparam logic [CW-1:0] CNT_FULL = CW'(`FIFO_DEPTH);

    fe_state_t     state;
    logic          op_read;
    logic [DW-1:0] div_cnt;
    logic [BW-1:0] bit_cnt;
    sample_t       tx_sr;
    sample_t       rx_sr;
    logic          xfer;
    logic          tick;
    logic          push;
    logic          pop;

    sample_t       mem [`FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign xfer = (state == CONF_XFER) || (state == READ_XFER);
    assign tick = xfer && (div_cnt == DIV_LAST); // SCLK edge due.
    assign push = tick && sclk && (bit_cnt == BIT_LAST) && (state == READ_XFER);
    assign pop  = bus.smp_valid && bus.smp_ready;
    assign mosi = !cs_n && tx_sr[`SMP_W-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            op_read <= 1'b0;
            cs_n    <= 1'b1;
            sclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            if (xfer) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (bus.fs_conf) begin
                        op_read <= 1'b0;
                        cs_n    <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= CONF_XFER;
                    end else if (bus.fs_read) begin
                        op_read <= 1'b1;
                        state   <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    if (!bus.fifo_full) begin // Hold off until there is room.
                        cs_n    <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= READ_XFER;
                    end
                end
                CONF_XFER, READ_XFER: begin
                    if (tick) begin
                        sclk <= !sclk;
                        if (sclk) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_LAST) begin
                                cs_n  <= 1'b1;
                                state <= DONE;
                            end
                        end
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // MOSI moves on the falling edge, MISO is taken on the rising edge.
    always_ff @(posedge clk) begin
        if (state == IDLE && bus.fs_conf) begin
            tx_sr <= {cmd, {(`SMP_W-8){1'b0}}};
        end else if (state == READ_WAIT) begin
            tx_sr <= '0;
        end else if (tick && sclk) begin
            tx_sr <= {tx_sr[`SMP_W-2:0], 1'b0};
        end
        if (tick && !sclk) begin
            rx_sr <= {rx_sr[`SMP_W-2:0], miso};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_sr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    assign bus.smp       = mem[rd_ptr];
    assign bus.smp_valid = (count != '0);
    assign bus.fifo_full = (count == CNT_FULL);
    assign bus.fd_conf   = (state == DONE) && !op_read;
    assign bus.fd_read   = (state == DONE) && op_read;

    // The space check in READ_WAIT must still hold when the sample lands.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count < CNT_FULL));

    a_cs_held: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> !cs_n);

endmodule

`default_nettype wire

/* design/intan_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface intan_if;
    import adc_pkg::*;

    logic    fs_conf;   // Start strobes.
    logic    fs_read;
    logic    fd_conf;   // Done strobes.
    logic    fd_read;

    // Head of the slot FIFO.
    sample_t smp;
    logic    smp_valid;
    logic    smp_ready;
    logic    fifo_full;

    modport ctrl (
        output fs_conf,
        output fs_read,
        input  fd_conf,
        input  fd_read
    );

    modport fe (
        input  fs_conf,
        input  fs_read,
        input  smp_ready,
        output fd_conf,
        output fd_read,
        output smp,
        output smp_valid,
        output fifo_full
    );

    modport drain (
        input  smp,
        input  smp_valid,
        output smp_ready
    );

endinterface

`default_nettype wire

/* design/slot_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_defs.svh"

module slot_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fs_conf,
    input  logic                 fs_read,
    input  logic [2*`N_SLOT-1:0] dev_kind,
    output logic                 fd_conf,
    output logic                 fd_read,
    intan_if.ctrl                slots [`N_SLOT]
);
    import adc_pkg::*;

    logic               busy;
    logic               op_conf;
    logic [`N_SLOT-1:0] present;
    logic [`N_SLOT-1:0] act;      // Slots taking part in the running operation.
    logic [`N_SLOT-1:0] got;      // Sticky done mask.
    logic [`N_SLOT-1:0] done_in;
    logic [`N_SLOT-1:0] done_now;
    logic               start;
    logic               none;
    logic               all_done;

    assign start    = (fs_conf || fs_read) && !busy;
    assign none     = start && !(|present);
    assign done_now = got | done_in;
    assign all_done = busy && (&(done_now | ~act));

    for (genvar i = 0; i < `N_SLOT; i++) begin : g_slot
        kind_t kind;

        assign kind       = dev_kind[2*i +: 2];
        assign present[i] = (kind != 2'b00);

        // Configure wins if both strobes come together.
        assign slots[i].fs_conf = start && fs_conf && present[i];
        assign slots[i].fs_read = start && !fs_conf && present[i];
        assign done_in[i]       = slots[i].fd_conf || slots[i].fd_read;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            op_conf <= 1'b0;
            act     <= '0;
            got     <= '0;
            fd_conf <= 1'b0;
            fd_read <= 1'b0;
        end else begin
            // No device present, done answers the start at once.
            fd_conf <= (none && fs_conf) || (all_done && op_conf);
            fd_read <= (none && !fs_conf) || (all_done && !op_conf);
            if (start && !none) begin
                busy    <= 1'b1;
                op_conf <= fs_conf;
                act     <= present;
                got     <= '0;
            end else if (all_done) begin
                busy <= 1'b0;
            end else if (busy) begin
                got <= done_now;
            end
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        (fs_conf || fs_read) |-> !busy);

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/adc_pkg.sv
design/intan_if.sv
design/slot_ctrl.sv
design/intan.sv
design/fifo2adc.sv
design/adc.sv
bench/clk_gen.sv
bench/conv_model.sv
bench/adc_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module adc_tb -f project.f -o adc_sim \
    && ./obj_dir/adc_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }
